// File: list.f
verilog/recoveryPkg.sv
verilog/schedulerPkg.sv
verilog/issuePipeLane.sv
verilog/flushWindowTracker.sv
verilog/wakeupPipelineRegister.sv
tests/wakeupPipelineTb.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal -f list.f --top-module wakeupPipelineTb \
    -o wakeupPipelineSim
./obj_dir/wakeupPipelineSim

// File: tests/wakeupPipelineTb.sv
/*
 * Wakeup pipeline register testbench
 * Replays one stim file line per clock cycle and compares the wakeup,
 * release and flushedOpExist outputs with the expected values in that line
 */
`timescale 1ns/1ps

module wakeupPipelineTb;

    localparam int clkPeriod = 40;
    localparam int driveDelay = 2;
    localparam int maxLines = 64;
    localparam int edgeLimit = 4;
    localparam int nameChars = 16;
    localparam int fieldsPerLine = 34;
    localparam int width = schedulerPkg::issueWidth;

    logic clk;
    logic rstN;
    logic stall;
    schedulerPkg::selectedOp selected [width];
    schedulerPkg::iqOneHot flushIqEntry;
    recoveryPkg::recoveryReq recovery;
    schedulerPkg::wakeupOp wakeup [width];
    schedulerPkg::releaseOp releaseEntry [width];
    logic flushedOpExist;

    // Fields of the current stim line
    logic [8*nameChars-1:0] nameBits;
    logic [8*128-1:0] skipBuf;
    string testName;
    logic stimStall;
    logic slotValid [width];
    schedulerPkg::iqIndex slotPtr [width];
    schedulerPkg::iqOneHot slotDep [width];
    recoveryPkg::alIndex slotAl [width];
    schedulerPkg::iqOneHot stimFlushIq;
    logic recToRecovery;
    logic recFromRw;
    logic recFlushAll;
    recoveryPkg::alIndex recHead;
    recoveryPkg::alIndex recTail;
    logic [width-1:0] expWakeup;
    logic [width-1:0] expRelease;
    schedulerPkg::iqIndex expPtr [width];
    schedulerPkg::iqOneHot expDep [width];
    logic expFlushedOp;

    wakeupPipelineRegister dut (
        .clk            (clk),
        .rstN           (rstN),
        .stall          (stall),
        .selected       (selected),
        .flushIqEntry   (flushIqEntry),
        .recovery       (recovery),
        .wakeup         (wakeup),
        .releaseEntry   (releaseEntry),
        .flushedOpExist (flushedOpExist)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    task automatic stopOnFailure();
        $display("Test failed");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic waitRisingEdge();
        int toggles;
        toggles = 0;
        do begin
            @(clk);
            toggles++;
        end while (clk !== 1'b1 && toggles < edgeLimit);
        if (clk !== 1'b1) begin
            $display("the clock did not rise within %0d toggles", edgeLimit);
            stopOnFailure();
        end
    endtask

    task automatic checkValue(string what, logic [31:0] expected, logic [31:0] actual);
        assert (actual == expected) else begin
            $display("error in %s: %s expected %0h, actual %0h", testName, what, expected, actual);
            stopOnFailure();
        end
    endtask

    task automatic openStimFile(output int fd);
        fd = $fopen("tests/wakeupStim.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stim file tests/wakeupStim.txt");
            stopOnFailure();
        end
    endtask

    // Reads everything after the test name
    task automatic readFields(input int fd);
        int count;
        count = $fscanf(fd, "%h", stimStall);
        for (int i = 0; i < width; i++) begin
            count += $fscanf(fd, "%h %h %h %h", slotValid[i], slotPtr[i], slotDep[i], slotAl[i]);
        end
        count += $fscanf(fd, "%h %h %h", stimFlushIq, recToRecovery, recFromRw);
        count += $fscanf(fd, "%h %h %h", recFlushAll, recHead, recTail);
        count += $fscanf(fd, "%h %h", expWakeup, expRelease);
        for (int i = 0; i < width; i++) begin
            count += $fscanf(fd, "%h", expPtr[i]);
        end
        for (int i = 0; i < width; i++) begin
            count += $fscanf(fd, "%h", expDep[i]);
        end
        count += $fscanf(fd, "%h", expFlushedOp);
        if (count != fieldsPerLine) begin
            $display("stim line of test %s holds %0d fields, not %0d", testName, count,
                     fieldsPerLine);
            stopOnFailure();
        end
    endtask

    task automatic applyCycle();
        stall = stimStall;
        for (int i = 0; i < width; i++) begin
            selected[i].valid = slotValid[i];
            selected[i].ptr = slotPtr[i];
            // Idle slots carry random dependency bits
            selected[i].depVector = slotValid[i] ? slotDep[i] : schedulerPkg::iqOneHot'($urandom);
            selected[i].activeListPtr = slotAl[i];
        end
        flushIqEntry = stimFlushIq;
        recovery.toRecovery = recToRecovery;
        recovery.fromRwStage = recFromRw;
        recovery.range.flushAll = recFlushAll;
        recovery.range.headPtr = recHead;
        recovery.range.tailPtr = recTail;
    endtask

    task automatic checkCycle();
        for (int i = 0; i < width; i++) begin
            checkValue($sformatf("wakeup[%0d].valid", i), 32'(expWakeup[i]),
                       32'(wakeup[i].valid));
            checkValue($sformatf("release[%0d].valid", i), 32'(expRelease[i]),
                       32'(releaseEntry[i].valid));
            if (expWakeup[i]) begin
                checkValue($sformatf("wakeup[%0d].ptr", i), 32'(expPtr[i]), 32'(wakeup[i].ptr));
                checkValue($sformatf("wakeup[%0d].depVector", i), 32'(expDep[i]),
                           32'(wakeup[i].depVector));
            end
            if (expRelease[i]) begin
                checkValue($sformatf("release[%0d].ptr", i), 32'(expPtr[i]),
                           32'(releaseEntry[i].ptr));
            end
            // Integer lanes show no dependency bits while stalled
            if (i < schedulerPkg::intIssueWidth && stimStall) begin
                checkValue($sformatf("wakeup[%0d].depVector", i), 32'(0),
                           32'(wakeup[i].depVector));
            end
        end
        checkValue("flushedOpExist", 32'(expFlushedOp), 32'(flushedOpExist));
    endtask

    initial begin
        int fd;
        int count;
        int cycles;
        bit reachedEnd;
        void'($urandom(82306));
        rstN = 1'b0;
        stall = 1'b0;
        flushIqEntry = '0;
        recovery = '0;
        for (int i = 0; i < width; i++) begin
            selected[i] = '0;
        end
        openStimFile(fd);
        repeat (2) waitRisingEdge();
        #driveDelay;
        rstN = 1'b1;
        reachedEnd = 1'b0;
        cycles = 0;
        for (int lineNo = 0; lineNo < maxLines && !reachedEnd; lineNo++) begin
            count = $fscanf(fd, "%s", nameBits);
            if (count != 1) begin
                reachedEnd = 1'b1;
            end else begin
                testName = string'(nameBits);
                if (testName == "#") begin
                    void'($fgets(skipBuf, fd));
                end else begin
                    readFields(fd);
                    // The first line goes out together with the reset release
                    if (cycles > 0) begin
                        waitRisingEdge();
                        #driveDelay;
                    end
                    applyCycle();
                    #(clkPeriod - driveDelay - 1);
                    checkCycle();
                    cycles++;
                end
            end
        end
        $fclose(fd);
        if (!reachedEnd) begin
            $display("the stim file is longer than %0d lines", maxLines);
            stopOnFailure();
        end else if (cycles == 0) begin
            $display("the stim file holds no cycles");
            stopOnFailure();
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

// File: tests/wakeupStim.txt
# name stall, four slots as valid ptr depVector alPtr, flushIqEntry, toRecovery fromRwStage
# flushAll headPtr tailPtr, wakeup mask, release mask, four ptrs, four depVectors, flushedOpExist
idle 0 0 0 0000 00 0 0 0000 00 0 0 0000 00 0 0 0000 00 0000 0 0 0 00 00 0 0 0 0 0 0 0000 0000 0000 0000 0
intop 0 1 3 0008 04 1 5 0020 05 0 0 0000 00 0 0 0000 00 0000 0 0 0 00 00 0 0 0 0 0 0 0000 0000 0000 0000 0
intop 0 0 0 0000 00 0 0 0000 00 0 0 0000 00 0 0 0000 00 0000 0 0 0 00 00 3 3 3 5 0 0 0008 0020 0000 0000 0
intstl 0 1 6 0040 06 0 0 0000 00 0 0 0000 00 0 0 0000 00 0000 0 0 0 00 00 0 0 0 0 0 0 0000 0000 0000 0000 0
intstl 1 1 7 0080 07 0 0 0000 00 0 0 0000 00 0 0 0000 00 0000 0 0 0 00 00 0 0 0 0 0 0 0000 0000 0000 0000 0
intstl 0 0 0 0000 00 0 0 0000 00 0 0 0000 00 0 0 0000 00 0000 0 0 0 00 00 1 1 6 0 0 0 0040 0000 0000 0000 0
intstl 0 0 0 0000 00 0 0 0000 00 0 0 0000 00 0 0 0000 00 0000 0 0 0 00 00 0 0 0 0 0 0 0000 0000 0000 0000 0
mem 0 0 0 0000 00 0 0 0000 00 1 9 0200 08 0 0 0000 00 0000 0 0 0 00 00 0 0 0 0 0 0 0000 0000 0000 0000 0
mem 0 0 0 0000 00 0 0 0000 00 0 0 0000 00 0 0 0000 00 0000 0 0 0 00 00 0 0 0 0 0 0 0000 0000 0000 0000 0
mem 0 0 0 0000 00 0 0 0000 00 0 0 0000 00 0 0 0000 00 0000 0 0 0 00 00 0 0 0 0 0 0 0000 0000 0000 0000 0
mem 0 0 0 0000 00 0 0 0000 00 0 0 0000 00 0 0 0000 00 0000 0 0 0 00 00 4 4 0 0 9 0 0000 0000 0200 0000 0
mem 0 0 0 0000 00 0 0 0000 00 0 0 0000 00 0 0 0000 00 0000 0 0 0 00 00 0 0 0 0 0 0 0000 0000 0000 0000 0
memstl 0 0 0 0000 00 0 0 0000 00 0 0 0000 00 1 a 0400 09 0000 0 0 0 00 00 0 0 0 0 0 0 0000 0000 0000 0000 0
memstl 1 0 0 0000 00 0 0 0000 00 0 0 0000 00 1 b 0800 0a 0000 0 0 0 00 00 0 0 0 0 0 0 0000 0000 0000 0000 0
memstl 0 0 0 0000 00 0 0 0000 00 0 0 0000 00 0 0 0000 00 0000 0 0 0 00 00 0 0 0 0 0 0 0000 0000 0000 0000 0
memstl 0 0 0 0000 00 0 0 0000 00 0 0 0000 00 0 0 0000 00 0000 0 0 0 00 00 0 0 0 0 0 0 0000 0000 0000 0000 0
memstl 0 0 0 0000 00 0 0 0000 00 0 0 0000 00 0 0 0000 00 0000 0 0 0 00 00 8 8 0 0 0 a 0000 0000 0000 0400 0
memstl 0 0 0 0000 00 0 0 0000 00 0 0 0000 00 0 0 0000 00 0000 0 0 0 00 00 0 0 0 0 0 0 0000 0000 0000 0000 0
memstl 0 0 0 0000 00 0 0 0000 00 1 c 1000 0b 0 0 0000 00 0000 0 0 0 00 00 0 0 0 0 0 0 0000 0000 0000 0000 0
memstl 0 0 0 0000 00 0 0 0000 00 0 0 0000 00 0 0 0000 00 0000 0 0 0 00 00 0 0 0 0 0 0 0000 0000 0000 0000 0
memstl 0 0 0 0000 00 0 0 0000 00 0 0 0000 00 0 0 0000 00 0000 0 0 0 00 00 0 0 0 0 0 0 0000 0000 0000 0000 0
memstl 1 0 0 0000 00 0 0 0000 00 0 0 0000 00 0 0 0000 00 0000 0 0 0 00 00 4 4 0 0 c 0 0000 0000 1000 0000 0
memstl 0 0 0 0000 00 0 0 0000 00 0 0 0000 00 0 0 0000 00 0000 0 0 0 00 00 0 0 0 0 0 0 0000 0000 0000 0000 0
iqfl 0 1 2 0004 0c 1 1 0002 0e 1 4 0010 0d 0 0 0000 00 0014 0 0 0 00 00 0 0 0 0 0 0 0000 0000 0000 0000 0
iqfl 0 0 0 0000 00 0 0 0000 00 0 0 0000 00 0 0 0000 00 0000 0 0 0 00 00 2 2 0 1 0 0 0000 0002 0000 0000 0
iqfl 0 0 0 0000 00 0 0 0000 00 0 0 0000 00 0 0 0000 00 0000 0 0 0 00 00 0 0 0 0 0 0 0000 0000 0000 0000 0
iqfl 0 0 0 0000 00 0 0 0000 00 0 0 0000 00 0 0 0000 00 0000 0 0 0 00 00 0 0 0 0 0 0 0000 0000 0000 0000 0
full 0 1 3 0008 10 0 0 0000 00 1 5 0020 11 0 0 0000 00 0000 0 0 0 00 00 0 0 0 0 0 0 0000 0000 0000 0000 0
full 0 0 0 0000 00 1 6 0040 12 0 0 0000 00 0 0 0000 00 0000 1 0 0 00 00 1 1 3 0 0 0 0008 0000 0000 0000 0
full 0 0 0 0000 00 0 0 0000 00 0 0 0000 00 0 0 0000 00 0000 0 0 0 00 00 0 0 0 0 0 0 0000 0000 0000 0000 0
full 0 0 0 0000 00 0 0 0000 00 0 0 0000 00 0 0 0000 00 0000 0 0 0 00 00 0 0 0 0 0 0 0000 0000 0000 0000 0
full 0 0 0 0000 00 0 0 0000 00 0 0 0000 00 0 0 0000 00 0000 0 0 0 00 00 0 0 0 0 0 0 0000 0000 0000 0000 0
sel 0 0 0 0000 00 0 0 0000 00 1 3 0008 05 1 4 0010 0a 0000 0 0 0 00 00 0 0 0 0 0 0 0000 0000 0000 0000 0
sel 0 1 1 0002 03 1 2 0004 09 0 0 0000 00 0 0 0000 00 0000 1 1 0 02 08 0 0 0 0 0 0 0000 0000 0000 0000 0
sel 0 0 0 0000 00 0 0 0000 00 0 0 0000 00 0 0 0000 00 0000 0 0 0 00 00 2 3 1 2 0 0 0000 0004 0000 0000 1
sel 0 0 0 0000 00 0 0 0000 00 0 0 0000 00 0 0 0000 00 0000 0 0 0 00 00 8 c 0 0 3 4 0000 0000 0000 0010 1
sel 0 0 0 0000 00 0 0 0000 00 0 0 0000 00 0 0 0000 00 0000 0 0 0 00 00 0 0 0 0 0 0 0000 0000 0000 0000 1
sel 0 0 0 0000 00 0 0 0000 00 0 0 0000 00 0 0 0000 00 0000 0 0 0 00 00 0 0 0 0 0 0 0000 0000 0000 0000 0

// File: verilog/flushWindowTracker.sv
/*
 * Flush window tracker
 * Latches the range of a selective recovery and counts, per class, how long
 * flushed ops may still sit in the tracking chains
 */
`timescale 1ns/1ps

module flushWindowTracker (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      stall,
    input  recoveryPkg::recoveryReq   recovery,
    output recoveryPkg::flushRange    range,
    output logic                      intCanBeFlushed,
    output logic                      memCanBeFlushed,
    output logic                      flushedOpExist
);

    localparam schedulerPkg::latencyCount intFull =
        schedulerPkg::latencyCount'(schedulerPkg::intLatency);
    localparam schedulerPkg::latencyCount memFull =
        schedulerPkg::latencyCount'(schedulerPkg::memLatency);

    schedulerPkg::latencyCount intCount;
    schedulerPkg::latencyCount memCount;
    logic selectiveRecovery;

    // The first stage only advances when not stalled
    function automatic schedulerPkg::latencyCount countDown(
        schedulerPkg::latencyCount count,
        schedulerPkg::latencyCount full,
        logic                      hold
    );
        schedulerPkg::latencyCount next;
        next = count;
        if (count == full) begin
            if (!hold) begin
                next = count - 1'b1;
            end
        end else if (count != '0) begin
            next = count - 1'b1;
        end
        return next;
    endfunction

    assign selectiveRecovery = recovery.toRecovery && recovery.fromRwStage;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            range <= '0;
            intCount <= '0;
            memCount <= '0;
        end else if (selectiveRecovery) begin
            range <= recovery.range;
            intCount <= intFull;
            memCount <= memFull;
        end else begin
            intCount <= countDown(intCount, intFull, stall);
            memCount <= countDown(memCount, memFull, stall);
        end
    end

    assign intCanBeFlushed = (intCount != '0);
    assign memCanBeFlushed = (memCount != '0);

    // Tells the recovery manager that some chain may still hold flushed ops
    assign flushedOpExist = intCanBeFlushed || memCanBeFlushed;

endmodule

// File: verilog/issuePipeLane.sv
/*
 * Issue pipe lane
 * Tracks ops issued on one slot through a chain of stages, then wakes up
 * their consumers and releases their issue-queue entries
 */
`timescale 1ns/1ps

module issuePipeLane #(
    parameter int latency = 1
) (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      stall,
    input  logic                      flushAll,
    input  schedulerPkg::selectedOp   slot,
    input  schedulerPkg::iqOneHot     flushIqEntry,
    input  logic                      canBeFlushed,
    input  recoveryPkg::flushRange    range,
    output schedulerPkg::wakeupOp     wakeup,
    output schedulerPkg::releaseOp    releaseEntry
);

    // Stage latency-1 is filled from select, stage 0 drives the outputs
    schedulerPkg::selectedOp stage [latency];
    schedulerPkg::selectedOp nextStage;
    logic flushedOp;
    logic outGate;

    // Drop an op whose IQ entry is flushed in the cycle it is selected
    always_comb begin
        nextStage = slot;
        nextStage.valid = slot.valid && !flushIqEntry[slot.ptr];
    end

    generate
        if (latency == 1) begin : gSingle
            always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                    stage[0] <= '0;
                end else if (flushAll) begin
                    stage[0].valid <= 1'b0;
                end else if (!stall) begin
                    stage[0] <= nextStage;
                end
            end
        end else begin : gChain
            always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                    for (int j = 0; j < latency; j++) begin
                        stage[j] <= '0;
                    end
                end else if (flushAll) begin
                    for (int j = 0; j < latency; j++) begin
                        stage[j].valid <= 1'b0;
                    end
                end else begin
                    // Lower stages advance regardless of stall
                    for (int j = 1; j < latency - 1; j++) begin
                        stage[j-1] <= stage[j];
                    end
                    if (stall) begin
                        // First stage holds, a bubble goes behind it
                        stage[latency-2].valid <= 1'b0;
                        stage[latency-2].depVector <= '0;
                    end else begin
                        stage[latency-2] <= stage[latency-1];
                        stage[latency-1] <= nextStage;
                    end
                end
            end
        end
    endgenerate

    // Only a single-stage lane shows a held entry during stall
    assign outGate = (latency == 1) ? stall : 1'b0;

    // Flushed by a selective recovery while still in flight
    assign flushedOp = canBeFlushed && recoveryPkg::inFlushRange(range, stage[0].activeListPtr);

    always_comb begin
        wakeup.valid = stage[0].valid && !flushedOp && !outGate;
        wakeup.ptr = stage[0].ptr;
        wakeup.depVector = outGate ? '0 : stage[0].depVector;
    end

    // Entries are freed even when their wakeup is suppressed
    always_comb begin
        releaseEntry.valid = stage[0].valid && !outGate;
        releaseEntry.ptr = stage[0].ptr;
    end

endmodule

// File: verilog/recoveryPkg.sv
/*
 * Recovery definitions
 * Active-list pointer type, the recovery request coming from the recovery
 * manager and the check whether an op lies in a flushed range
 */
package recoveryPkg;

    localparam int alEntries = 32;
    typedef logic [$clog2(alEntries)-1:0] alIndex;

    // Flushed active-list span, tail is exclusive
    typedef struct packed {
        logic flushAll;
        alIndex headPtr;
        alIndex tailPtr;
    } flushRange;

    typedef struct packed {
        logic toRecovery;
        logic fromRwStage;
        flushRange range;
    } recoveryReq;

    // True when ptr falls inside the circular span [headPtr, tailPtr)
    function automatic logic inFlushRange(flushRange r, alIndex ptr);
        logic hit;
        if (r.flushAll) begin
            hit = 1'b1;
        end else if (r.headPtr == r.tailPtr) begin
            hit = 1'b0;
        end else if (r.headPtr < r.tailPtr) begin
            hit = (ptr >= r.headPtr) && (ptr < r.tailPtr);
        end else begin
            // Span wraps past the last entry
            hit = (ptr >= r.headPtr) || (ptr < r.tailPtr);
        end
        return hit;
    endfunction

endpackage

// File: verilog/schedulerPkg.sv
/*
 * Scheduler definitions
 * Issue-queue widths, per-class latencies, issue-slot counts and the
 * packed records exchanged between select, the wakeup pipeline and the IQ
 */
package schedulerPkg;

    // Issue queue geometry
    localparam int iqEntries = 16;
    typedef logic [$clog2(iqEntries)-1:0] iqIndex;
    typedef logic [iqEntries-1:0] iqOneHot;

    // Issue slots, integer lanes first and memory lanes after them
    localparam int intIssueWidth = 2;
    localparam int memIssueWidth = 2;
    localparam int issueWidth = intIssueWidth + memIssueWidth;

    // Tracking stages per class
    localparam int intLatency = 1;
    localparam int memLatency = 3;

    // Wide enough to hold the longest class latency
    typedef logic [$clog2(memLatency+1)-1:0] latencyCount;

    // An op picked by select logic this cycle
    typedef struct packed {
        logic valid;
        iqIndex ptr;
        iqOneHot depVector;
        recoveryPkg::alIndex activeListPtr;
    } selectedOp;

    // Broadcast to the producer matrix
    typedef struct packed {
        logic valid;
        iqIndex ptr;
        iqOneHot depVector;
    } wakeupOp;

    // Frees one issue-queue entry
    typedef struct packed {
        logic valid;
        iqIndex ptr;
    } releaseOp;

endpackage

// File: verilog/wakeupPipelineRegister.sv
/*
 * Wakeup pipeline register
 * Places the integer and memory tracking lanes and the flush window tracker
 */
`timescale 1ns/1ps

module wakeupPipelineRegister (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      stall,
    input  schedulerPkg::selectedOp   selected [schedulerPkg::issueWidth],
    input  schedulerPkg::iqOneHot     flushIqEntry,
    input  recoveryPkg::recoveryReq   recovery,
    output schedulerPkg::wakeupOp     wakeup [schedulerPkg::issueWidth],
    output schedulerPkg::releaseOp    releaseEntry [schedulerPkg::issueWidth],
    output logic                      flushedOpExist
);

    logic fullRecovery;
    logic intCanBeFlushed;
    logic memCanBeFlushed;
    recoveryPkg::flushRange range;

    // Recovery not issued from the register-write stage clears everything
    assign fullRecovery = recovery.toRecovery && !recovery.fromRwStage;

    flushWindowTracker tracker (
        .clk             (clk),
        .rstN            (rstN),
        .stall           (stall),
        .recovery        (recovery),
        .range           (range),
        .intCanBeFlushed (intCanBeFlushed),
        .memCanBeFlushed (memCanBeFlushed),
        .flushedOpExist  (flushedOpExist)
    );

    generate
        for (genvar i = 0; i < schedulerPkg::intIssueWidth; i++) begin : gIntLane
            issuePipeLane #(
                .latency (schedulerPkg::intLatency)
            ) lane (
                .clk          (clk),
                .rstN         (rstN),
                .stall        (stall),
                .flushAll     (fullRecovery),
                .slot         (selected[i]),
                .flushIqEntry (flushIqEntry),
                .canBeFlushed (intCanBeFlushed),
                .range        (range),
                .wakeup       (wakeup[i]),
                .releaseEntry (releaseEntry[i])
            );
        end

        // Memory slots follow the integer slots
        for (genvar i = 0; i < schedulerPkg::memIssueWidth; i++) begin : gMemLane
            issuePipeLane #(
                .latency (schedulerPkg::memLatency)
            ) lane (
                .clk          (clk),
                .rstN         (rstN),
                .stall        (stall),
                .flushAll     (fullRecovery),
                .slot         (selected[schedulerPkg::intIssueWidth+i]),
                .flushIqEntry (flushIqEntry),
                .canBeFlushed (memCanBeFlushed),
                .range        (range),
                .wakeup       (wakeup[schedulerPkg::intIssueWidth+i]),
                .releaseEntry (releaseEntry[schedulerPkg::intIssueWidth+i])
            );
        end
    endgenerate

endmodule
